// File: hw/cpu_pkg.sv
package cpu_pkg;

    // ----------------------------------------
    // alu operations
    // ----------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // branch kinds carried in ctrl_t.br_kind
    localparam logic [1:0] BR_NONE   = 2'd0;
    localparam logic [1:0] BR_EQ     = 2'd1;
    localparam logic [1:0] BR_NE     = 2'd2;
    localparam logic [1:0] BR_ALWAYS = 2'd3;

    // ----------------------------------------
    // decoded instruction
    // ----------------------------------------
    typedef struct packed {
        alu_op_e     alu_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        res_from_mem;
        logic        gr_we;
        logic        mem_we;
        logic [1:0]  br_kind;
        logic        is_jirl;
        logic [4:0]  dest;
        logic [4:0]  rj;
        logic [4:0]  rkd;        // rd for beq/bne/st.w, rk otherwise
        logic [31:0] imm;
        logic [31:0] br_offs;    // already shifted left by two
        logic        illegal;
    } ctrl_t;

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // one record per cycle, rf_we marks a retired register write
    typedef struct packed {
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
    } trace_t;

endpackage

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e op,
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    output logic [31:0]      result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  result = src1 + src2;
            cpu_pkg::ALU_SUB:  result = src1 - src2;
            cpu_pkg::ALU_SLT:  result = {31'd0, lt_signed};
            cpu_pkg::ALU_SLTU: result = {31'd0, lt_unsigned};
            cpu_pkg::ALU_AND:  result = src1 & src2;
            cpu_pkg::ALU_NOR:  result = ~(src1 | src2);
            cpu_pkg::ALU_OR:   result = src1 | src2;
            cpu_pkg::ALU_XOR:  result = src1 ^ src2;
            cpu_pkg::ALU_SLL:  result = src1 << shamt;
            cpu_pkg::ALU_SRL:  result = src1 >> shamt;
            cpu_pkg::ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);
            cpu_pkg::ALU_LUI:  result = src2;  // imm is already si20<<12
            default:           result = 32'd0;
        endcase
    end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] rf [32];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin  // r0 is hardwired
            rf[waddr] <= wdata;
        end
    end

    // combinational reads, r0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]    instr,
    output cpu_pkg::ctrl_t ctrl
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;

    logic        is_3r;    // three-register group
    logic        is_2ri5;  // shift-by-immediate group
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic        inst_beq, inst_bne, inst_b, inst_bl, inst_jirl;
    logic        legal;

    logic        need_ui5, need_si20, need_si26, src2_is_4;
    logic [31:0] si12_ext;
    logic [31:0] ui5_ext;
    logic [31:0] si20_shl;
    logic [31:0] si16_offs;
    logic [31:0] si26_offs;

    assign op_31_26 = instr[31:26];
    assign op_25_22 = instr[25:22];
    assign op_21_20 = instr[21:20];
    assign op_19_15 = instr[19:15];
    assign rd       = instr[4:0];
    assign rj       = instr[9:5];
    assign rk       = instr[14:10];

    // ----------------------------------------
    // opcode match
    // ----------------------------------------
    assign is_3r   = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign is_2ri5 = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = is_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = is_3r && (op_19_15 == 5'h02);
    assign inst_slt     = is_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = is_3r && (op_19_15 == 5'h05);
    assign inst_nor     = is_3r && (op_19_15 == 5'h08);
    assign inst_and     = is_3r && (op_19_15 == 5'h09);
    assign inst_or      = is_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = is_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = is_2ri5 && (op_19_15 == 5'h01);
    assign inst_srli_w  = is_2ri5 && (op_19_15 == 5'h09);
    assign inst_srai_w  = is_2ri5 && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !instr[25];
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);

    assign legal = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                 | inst_or | inst_xor | inst_slli_w | inst_srli_w | inst_srai_w
                 | inst_addi_w | inst_lu12i_w | inst_ld_w | inst_st_w
                 | inst_beq | inst_bne | inst_b | inst_bl | inst_jirl;

    // ----------------------------------------
    // immediates
    // ----------------------------------------
    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = inst_jirl | inst_bl;  // link value is pc+4

    assign si12_ext  = {{20{instr[21]}}, instr[21:10]};
    assign ui5_ext   = {27'd0, instr[14:10]};
    assign si20_shl  = {instr[24:5], 12'd0};
    assign si16_offs = {{14{instr[25]}}, instr[25:10], 2'b00};
    assign si26_offs = {{4{instr[9]}}, instr[9:0], instr[25:10], 2'b00};

    always_comb begin
        ctrl = '0;

        if (inst_sub_w)                     ctrl.alu_op = cpu_pkg::ALU_SUB;
        else if (inst_slt)                  ctrl.alu_op = cpu_pkg::ALU_SLT;
        else if (inst_sltu)                 ctrl.alu_op = cpu_pkg::ALU_SLTU;
        else if (inst_and)                  ctrl.alu_op = cpu_pkg::ALU_AND;
        else if (inst_nor)                  ctrl.alu_op = cpu_pkg::ALU_NOR;
        else if (inst_or)                   ctrl.alu_op = cpu_pkg::ALU_OR;
        else if (inst_xor)                  ctrl.alu_op = cpu_pkg::ALU_XOR;
        else if (inst_slli_w)               ctrl.alu_op = cpu_pkg::ALU_SLL;
        else if (inst_srli_w)               ctrl.alu_op = cpu_pkg::ALU_SRL;
        else if (inst_srai_w)               ctrl.alu_op = cpu_pkg::ALU_SRA;
        else if (inst_lu12i_w)              ctrl.alu_op = cpu_pkg::ALU_LUI;
        else                                ctrl.alu_op = cpu_pkg::ALU_ADD;

        ctrl.src1_is_pc   = inst_jirl | inst_bl | inst_b;
        ctrl.src2_is_imm  = need_ui5 | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w
                          | inst_jirl | inst_bl | inst_b;
        ctrl.res_from_mem = inst_ld_w;
        ctrl.gr_we        = legal & ~inst_st_w & ~inst_beq & ~inst_bne & ~inst_b;
        ctrl.mem_we       = inst_st_w;

        if (inst_b | inst_bl | inst_jirl) ctrl.br_kind = cpu_pkg::BR_ALWAYS;
        else if (inst_beq)                ctrl.br_kind = cpu_pkg::BR_EQ;
        else if (inst_bne)                ctrl.br_kind = cpu_pkg::BR_NE;
        else                              ctrl.br_kind = cpu_pkg::BR_NONE;
        ctrl.is_jirl = inst_jirl;

        ctrl.dest = inst_bl ? 5'd1 : rd;
        ctrl.rj   = rj;
        ctrl.rkd  = (inst_beq | inst_bne | inst_st_w) ? rd : rk;

        ctrl.imm = src2_is_4 ? 32'd4    :
                   need_si20 ? si20_shl :
                   need_ui5  ? ui5_ext  : si12_ext;
        ctrl.br_offs = need_si26 ? si26_offs : si16_offs;  // jirl uses si16 too
        ctrl.illegal = ~legal;
    end

endmodule

// File: hw/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::ctrl_t ctrl,
    input  logic [31:0]    rj_value,
    input  logic [31:0]    rkd_value,
    output logic [31:0]    pc,
    output logic           valid
);

    logic        rj_eq_rkd;
    logic        br_taken;
    logic [31:0] seq_pc;
    logic [31:0] br_target;
    logic [31:0] next_pc;

    assign rj_eq_rkd = (rj_value == rkd_value);

    always_comb begin
        case (ctrl.br_kind)
            cpu_pkg::BR_ALWAYS: br_taken = 1'b1;
            cpu_pkg::BR_EQ:     br_taken = rj_eq_rkd;
            cpu_pkg::BR_NE:     br_taken = !rj_eq_rkd;
            default:            br_taken = 1'b0;
        endcase
    end

    // ----------------------------------------
    // next pc
    // ----------------------------------------
    assign seq_pc    = pc + 32'd4;
    assign br_target = ctrl.is_jirl ? (rj_value + ctrl.br_offs) : (pc + ctrl.br_offs);
    assign next_pc   = br_taken ? br_target : seq_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= RESET_PC;
            valid <= 1'b0;
        end else begin
            valid <= 1'b1;
            if (valid) begin  // first cycle out of reset fetches RESET_PC
                pc <= next_pc;
            end
        end
    end

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic              clk,
    input  logic              reset,
    output logic [31:0]       inst_addr,
    input  logic [31:0]       inst_rdata,
    output cpu_pkg::mem_req_t data_req,
    input  logic [31:0]       data_rdata,
    output cpu_pkg::trace_t   trace
);

    logic [31:0]    pc;
    logic           valid;
    cpu_pkg::ctrl_t ctrl;
    logic [31:0]    rj_value;
    logic [31:0]    rkd_value;
    logic [31:0]    alu_src1;
    logic [31:0]    alu_src2;
    logic [31:0]    alu_result;
    logic [31:0]    final_result;
    logic           rf_we;

    // ----------------------------------------
    // fetch and decode
    // ----------------------------------------
    pc_unit #(.RESET_PC(RESET_PC)) u_pc (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .pc        (pc),
        .valid     (valid)
    );

    assign inst_addr = pc;

    inst_decoder u_dec (
        .instr (inst_rdata),
        .ctrl  (ctrl)
    );

    regfile u_rf (
        .clk    (clk),
        .raddr1 (ctrl.rj),
        .raddr2 (ctrl.rkd),
        .we     (rf_we),
        .waddr  (ctrl.dest),
        .wdata  (final_result),
        .rdata1 (rj_value),
        .rdata2 (rkd_value)
    );

    // ----------------------------------------
    // execute, memory, writeback
    // ----------------------------------------
    assign alu_src1 = ctrl.src1_is_pc  ? pc : rj_value;
    assign alu_src2 = ctrl.src2_is_imm ? ctrl.imm : rkd_value;

    alu u_alu (
        .op     (ctrl.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign data_req = '{we: valid & ctrl.mem_we, addr: alu_result, wdata: rkd_value};

    assign final_result = ctrl.res_from_mem ? data_rdata : alu_result;
    assign rf_we        = valid & ctrl.gr_we & (ctrl.dest != 5'd0);  // r0 writes never retire

    assign trace = '{pc: pc, rf_we: rf_we, rf_wnum: ctrl.dest, rf_wdata: final_result};

endmodule

// File: test/cpu_top_props.sv
`timescale 1ns/1ps

module cpu_top_props (
    input logic              clk,
    input logic              reset,
    input logic [31:0]       inst_addr,
    input cpu_pkg::mem_req_t data_req,
    input cpu_pkg::trace_t   trace
);

    // outputs are sampled mid-cycle, after the core has settled

    // ----------------------------------------
    // reset
    // ----------------------------------------
    rf_we_low_in_reset: assert property (@(negedge clk) reset |-> !trace.rf_we)
        else $error("register write retired while reset was high");

    mem_we_low_in_reset: assert property (@(negedge clk) reset |-> !data_req.we)
        else $error("memory write issued while reset was high");

    // ----------------------------------------
    // fetch and writeback
    // ----------------------------------------
    fetch_aligned: assert property (@(negedge clk) inst_addr[1:0] == 2'b00)
        else $error("instruction address is not word aligned");

    no_r0_write: assert property (@(negedge clk) trace.rf_we |-> trace.rf_wnum != 5'd0)
        else $error("trace shows a write to r0");

endmodule

bind cpu_top cpu_top_props props0 (
    .clk       (clk),
    .reset     (reset),
    .inst_addr (inst_addr),
    .data_req  (data_req),
    .trace     (trace)
);

// File: test/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

    localparam logic [31:0] RESET_PC   = 32'h1c00_0000;
    localparam int          PROG_WORDS = 34;
    localparam int          TIMEOUT_CYCLES = PROG_WORDS * 4 * 3;  // generous for branches

    logic              clk;
    logic              reset;
    logic [31:0]       inst_addr;
    logic [31:0]       inst_rdata;
    cpu_pkg::mem_req_t data_req;
    logic [31:0]       data_rdata;
    cpu_pkg::trace_t   trace;

    logic [31:0] rom [1024];
    logic [31:0] ram [256];
    logic [31:0] inst_off;

    // reference state
    logic [31:0] ref_pc;
    logic [31:0] ref_rf [32];
    logic [31:0] ref_mem [256];
    int          same_pc;
    int          cycles;

    cpu_top #(.RESET_PC(RESET_PC)) dut0 (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .data_req   (data_req),
        .data_rdata (data_rdata),
        .trace      (trace)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // memory models
    // ----------------------------------------
    function automatic logic [31:0] fill_word(input int idx);
        return 32'hda7a_0000 | (idx << 2);  // byte address in the low bits
    endfunction

    initial $readmemh("test/program.hex", rom);

    assign inst_off   = inst_addr - RESET_PC;
    assign inst_rdata = rom[inst_off[11:2]];
    assign data_rdata = ram[data_req.addr[9:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) ram[i[7:0]] <= fill_word(i);
        end else if (data_req.we) begin
            ram[data_req.addr[9:2]] <= data_req.wdata;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // executes one instruction in the reference model and compares the DUT outputs
    task automatic step_and_compare();
        logic [31:0] pc_off, ins, vj, vk, vd;
        logic [31:0] si12, off16, off26, mem_addr, val, npc;
        logic [4:0]  rd, rj, rk, wnum;
        logic        wr, st;

        pc_off = ref_pc - RESET_PC;
        ins    = rom[pc_off[11:2]];
        rd = ins[4:0];
        rj = ins[9:5];
        rk = ins[14:10];
        vj = ref_rf[rj];
        vk = ref_rf[rk];
        vd = ref_rf[rd];
        si12  = {{20{ins[21]}}, ins[21:10]};
        off16 = {{14{ins[25]}}, ins[25:10], 2'b00};
        off26 = {{4{ins[9]}}, ins[9:0], ins[25:10], 2'b00};
        mem_addr = vj + si12;
        val  = 32'd0;
        wnum = rd;
        wr   = 1'b1;
        st   = 1'b0;
        npc  = ref_pc + 32'd4;

        if (ins[31:15] == 17'h00020)      val = vj + vk;                      // add.w
        else if (ins[31:15] == 17'h00022) val = vj - vk;                      // sub.w
        else if (ins[31:15] == 17'h00024) val = ($signed(vj) < $signed(vk)) ? 32'd1 : 32'd0;
        else if (ins[31:15] == 17'h00025) val = (vj < vk) ? 32'd1 : 32'd0;    // sltu
        else if (ins[31:15] == 17'h00028) val = ~(vj | vk);
        else if (ins[31:15] == 17'h00029) val = vj & vk;
        else if (ins[31:15] == 17'h0002a) val = vj | vk;
        else if (ins[31:15] == 17'h0002b) val = vj ^ vk;
        else if (ins[31:15] == 17'h00081) val = vj << ins[14:10];             // slli.w
        else if (ins[31:15] == 17'h00089) val = vj >> ins[14:10];             // srli.w
        else if (ins[31:15] == 17'h00091) val = $signed(vj) >>> ins[14:10];   // srai.w
        else if (ins[31:22] == 10'h00a)   val = vj + si12;                    // addi.w
        else if (ins[31:26] == 6'h05 && !ins[25]) val = {ins[24:5], 12'd0};   // lu12i.w
        else if (ins[31:22] == 10'h0a2)   val = ref_mem[mem_addr[9:2]];       // ld.w
        else if (ins[31:22] == 10'h0a6) begin                                 // st.w
            wr = 1'b0;
            st = 1'b1;
        end else if (ins[31:26] == 6'h13) begin                               // jirl
            val = ref_pc + 32'd4;
            npc = vj + off16;
        end else if (ins[31:26] == 6'h14) begin                               // b
            wr  = 1'b0;
            npc = ref_pc + off26;
        end else if (ins[31:26] == 6'h15) begin                               // bl
            val  = ref_pc + 32'd4;
            wnum = 5'd1;
            npc  = ref_pc + off26;
        end else if (ins[31:26] == 6'h16 || ins[31:26] == 6'h17) begin        // beq, bne
            wr = 1'b0;
            if ((vj == vd) == (ins[31:26] == 6'h16)) npc = ref_pc + off16;
        end else begin
            wr = 1'b0;  // illegal word is a no-op
        end
        wr = wr && (wnum != 5'd0);

        check_value("inst_addr", ref_pc, inst_addr);
        check_value("trace.pc", ref_pc, trace.pc);
        check_value("trace.rf_we", {31'd0, wr}, {31'd0, trace.rf_we});
        if (wr) begin
            check_value("trace.rf_wnum", {27'd0, wnum}, {27'd0, trace.rf_wnum});
            check_value("trace.rf_wdata", val, trace.rf_wdata);
            ref_rf[wnum] = val;
        end
        check_value("data_req.we", {31'd0, st}, {31'd0, data_req.we});
        if (st) begin
            check_value("data_req.addr", mem_addr, data_req.addr);
            check_value("data_req.wdata", vd, data_req.wdata);
            ref_mem[mem_addr[9:2]] = vd;
        end

        same_pc = (npc == ref_pc) ? same_pc + 1 : 0;
        ref_pc  = npc;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        reset   = 1'b1;
        ref_pc  = RESET_PC;
        same_pc = 0;
        for (int i = 0; i < 32; i++) ref_rf[i[4:0]] = 32'd0;
        for (int i = 0; i < 256; i++) ref_mem[i[7:0]] = fill_word(i);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);  // core starts fetching after this edge

        while (same_pc < 2) begin  // b 0 at the end loops on itself
            @(negedge clk);
            step_and_compare();
        end
        $display("All checks passed");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Checks failed");
        $fatal(1, "timeout: program did not reach its final loop");
    end

endmodule

// File: cpu_top.f
hw/cpu_pkg.sv
hw/alu.sv
hw/regfile.sv
hw/inst_decoder.sv
hw/pc_unit.sv
hw/cpu_top.sv
test/cpu_top_props.sv
test/tb_cpu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cpu_top simulation, exit status is the simulator's
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_cpu_top -f cpu_top.f -o sim_cpu_top

./obj_dir/sim_cpu_top

// File: test/program.hex
// one 32-bit instruction word per line, hex, first word at RESET_PC
// text after the word is the assembly for that word
15000021  // 00 lu12i.w r1, 0x80001
02bff421  // 01 addi.w  r1, r1, -3
02848c02  // 02 addi.w  r2, r0, 0x123
02bffc03  // 03 addi.w  r3, r0, -1
00100824  // 04 add.w   r4, r1, r2
00110445  // 05 sub.w   r5, r2, r1
00120826  // 06 slt     r6, r1, r2
00128827  // 07 sltu    r7, r1, r2
00140c28  // 08 nor     r8, r1, r3
00148829  // 09 and     r9, r1, r2
0015082a  // 10 or      r10, r1, r2
00158c2b  // 11 xor     r11, r1, r3
0040902c  // 12 slli.w  r12, r1, 4
0044a02d  // 13 srli.w  r13, r1, 8
0048fc2e  // 14 srai.w  r14, r1, 31
29804001  // 15 st.w    r1, r0, 0x10
29809002  // 16 st.w    r2, r0, 0x24
2880400f  // 17 ld.w    r15, r0, 0x10
28809010  // 18 ld.w    r16, r0, 0x24
28810011  // 19 ld.w    r17, r0, 0x40
580009e1  // 20 beq     r15, r1, +8  (taken)
02815412  // 21 addi.w  r18, r0, 0x55  (skipped)
5c000842  // 22 bne     r2, r2, +8  (not taken)
5c000843  // 23 bne     r2, r3, +8  (taken)
02815412  // 24 addi.w  r18, r0, 0x55  (skipped)
58000843  // 25 beq     r2, r3, +8  (not taken)
54000c00  // 26 bl      +12
02801440  // 27 addi.w  r0, r2, 5
50000c00  // 28 b       +12
4c000034  // 29 jirl    r20, r1, 0
02815412  // 30 addi.w  r18, r0, 0x55  (skipped)
4c000a80  // 31 jirl    r0, r20, 8
00150813  // 32 or      r19, r0, r2
50000000  // 33 b       0
